//--- hw/wb_pkg.sv
package wb_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 14;

    // number of architectural registers.
    localparam int reg_count = 1 << reg_addr_w;

    // instruction classes seen by the memory stage.
    typedef enum logic [2:0] {
        op_alu     = 3'd0,   // plain alu result.
        op_ld_w    = 3'd1,   // word load.
        op_ld_b    = 3'd2,   // signed byte load.
        op_st_w    = 3'd3,   // word store.
        op_csrwr   = 3'd4,   // csr write.
        op_syscall = 3'd5    // system call.
    } mem_op_e;

    // LoongArch ecode values, only those raised here.
    typedef enum logic [7:0] {
        ec_none = 8'h00,
        ec_ale  = 8'h09,     // address misaligned.
        ec_sys  = 8'h0b      // syscall.
    } ecode_e;

    // CSR numbers
    localparam logic [csr_addr_w-1:0] csr_crmd  = 14'h000;
    localparam logic [csr_addr_w-1:0] csr_estat = 14'h005;
    localparam logic [csr_addr_w-1:0] csr_era   = 14'h006;
    localparam logic [csr_addr_w-1:0] csr_badv  = 14'h007;
    localparam logic [csr_addr_w-1:0] csr_save0 = 14'h030;

    // crmd comes up in direct address mode, plv0, interrupts off.
    localparam logic [xlen-1:0] crmd_reset = 32'h0000_0008;

    // crmd fields cleared on exception entry.
    localparam int crmd_plv_lsb = 0;
    localparam int crmd_ie_bit  = 2;

    // estat ecode field.
    localparam int estat_ecode_lsb = 16;
    localparam int estat_ecode_msb = 21;
    localparam int estat_ecode_w   = estat_ecode_msb - estat_ecode_lsb + 1;

endpackage

//--- hw/mem_stage.sv
module mem_stage import wb_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  mem_op_e               in_op,
    input  logic [xlen-1:0]       in_pc,
    input  logic [reg_addr_w-1:0] in_dest,
    input  logic [xlen-1:0]       in_alu_result,
    input  logic [xlen-1:0]       in_mem_rdata,
    input  logic [csr_addr_w-1:0] in_csr_addr,
    input  logic [xlen-1:0]       in_csr_wdata,

    input  logic                  flush,
    input  logic                  w_allowin,

    output logic                  m_valid,
    output logic [xlen-1:0]       m_pc,
    output logic [xlen-1:0]       m_result,
    output logic                  m_rf_we,
    output logic [reg_addr_w-1:0] m_dest,
    output logic [xlen-1:0]       m_vaddr,
    output logic                  m_ex,
    output ecode_e                m_ecode,
    output logic                  m_csr_we,
    output logic [csr_addr_w-1:0] m_csr_addr,
    output logic [xlen-1:0]       m_csr_wdata
);

    mem_op_e         op_q;
    logic [xlen-1:0] alu_q;
    logic [xlen-1:0] rdata_q;
    logic [7:0]      ld_byte;
    logic            misaligned;

    // single-cycle stage, only blocked downstream or by flush.
    assign in_ready = !flush && (!m_valid || w_allowin);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            m_valid <= 1'b0;
        end else if (flush) begin
            m_valid <= 1'b0;
        end else if (in_ready) begin
            m_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            op_q        <= in_op;
            m_pc        <= in_pc;
            m_dest      <= in_dest;
            alu_q       <= in_alu_result;
            rdata_q     <= in_mem_rdata;
            m_csr_addr  <= in_csr_addr;
            m_csr_wdata <= in_csr_wdata;
        end
    end

    // byte lane picked by the low address bits.
    always_comb begin
        case (alu_q[1:0])
            2'd0:    ld_byte = rdata_q[7:0];
            2'd1:    ld_byte = rdata_q[15:8];
            2'd2:    ld_byte = rdata_q[23:16];
            default: ld_byte = rdata_q[31:24];
        endcase
    end

    always_comb begin
        case (op_q)
            op_ld_w: m_result = rdata_q;
            op_ld_b: m_result = {{(xlen-8){ld_byte[7]}}, ld_byte};
            default: m_result = alu_q;
        endcase
    end

    assign m_rf_we  = (op_q == op_alu) || (op_q == op_ld_w) || (op_q == op_ld_b);
    assign m_csr_we = (op_q == op_csrwr);

    // alu result is the effective address for memory ops.
    assign m_vaddr    = alu_q;
    assign misaligned = ((op_q == op_ld_w) || (op_q == op_st_w)) && (alu_q[1:0] != 2'b00);

    always_comb begin
        if (op_q == op_syscall) begin
            m_ex    = 1'b1;
            m_ecode = ec_sys;
        end else if (misaligned) begin
            m_ex    = 1'b1;
            m_ecode = ec_ale;
        end else begin
            m_ex    = 1'b0;
            m_ecode = ec_none;
        end
    end

endmodule

//--- hw/wb_stage.sv
module wb_stage import wb_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  flush,

    input  logic                  m_valid,
    output logic                  w_allowin,
    input  logic [xlen-1:0]       m_pc,
    input  logic [xlen-1:0]       m_result,
    input  logic                  m_rf_we,
    input  logic [reg_addr_w-1:0] m_dest,
    input  logic [xlen-1:0]       m_vaddr,
    input  logic                  m_ex,
    input  ecode_e                m_ecode,
    input  logic                  m_csr_we,
    input  logic [csr_addr_w-1:0] m_csr_addr,
    input  logic [xlen-1:0]       m_csr_wdata,

    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic [xlen-1:0]       rf_wdata,

    output logic                  ex_commit,
    output ecode_e                ex_ecode,
    output logic [xlen-1:0]       ex_pc,
    output logic [xlen-1:0]       ex_vaddr,
    output logic                  csr_we,
    output logic [csr_addr_w-1:0] csr_waddr,
    output logic [xlen-1:0]       csr_wdata,

    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    logic                  w_valid;
    logic                  w_live;
    logic [xlen-1:0]       pc_q;
    logic [xlen-1:0]       result_q;
    logic                  rf_we_q;
    logic [reg_addr_w-1:0] dest_q;
    logic [xlen-1:0]       vaddr_q;
    logic                  ex_q;
    ecode_e                ecode_q;
    logic                  csr_we_q;
    logic [csr_addr_w-1:0] csr_addr_q;
    logic [xlen-1:0]       csr_wdata_q;

    // always done in one cycle.
    assign w_allowin = !flush;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            w_valid <= 1'b0;
        end else if (flush) begin
            w_valid <= 1'b0;
        end else if (w_allowin) begin
            w_valid <= m_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (m_valid && w_allowin) begin
            pc_q        <= m_pc;
            result_q    <= m_result;
            rf_we_q     <= m_rf_we;
            dest_q      <= m_dest;
            vaddr_q     <= m_vaddr;
            ex_q        <= m_ex;
            ecode_q     <= m_ecode;
            csr_we_q    <= m_csr_we;
            csr_addr_q  <= m_csr_addr;
            csr_wdata_q <= m_csr_wdata;
        end
    end

    // a younger record sitting here during flush must not commit.
    assign w_live = w_valid && !flush;

    assign rf_we    = w_live && rf_we_q && !ex_q;
    assign rf_waddr = dest_q;
    assign rf_wdata = result_q;

    assign ex_commit = w_live && ex_q;
    assign ex_ecode  = ecode_q;
    assign ex_pc     = pc_q;
    assign ex_vaddr  = vaddr_q;
    assign csr_we    = w_live && csr_we_q;
    assign csr_waddr = csr_addr_q;
    assign csr_wdata = csr_wdata_q;

    assign debug_wb_pc       = pc_q;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest_q;
    assign debug_wb_rf_wdata = result_q;

endmodule

//--- hw/reg_file.sv
module reg_file import wb_pkg::*; (
    input  logic                  clk,

    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,

    input  logic [reg_addr_w-1:0] raddr,
    output logic [xlen-1:0]       rdata
);

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;   // r0 never written.
        end
    end

    // read is not bypassed with the write port.
    assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

//--- hw/csr_file.sv
module csr_file import wb_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,

    input  logic                  ex_commit,
    input  ecode_e                ex_ecode,
    input  logic [xlen-1:0]       ex_pc,
    input  logic [xlen-1:0]       ex_vaddr,

    input  logic                  csr_we,
    input  logic [csr_addr_w-1:0] csr_waddr,
    input  logic [xlen-1:0]       csr_wdata,

    input  logic [csr_addr_w-1:0] raddr,
    output logic [xlen-1:0]       rdata,

    output logic                  flush,
    output ecode_e                ecode_q
);

    logic [xlen-1:0] crmd;
    logic [xlen-1:0] era;
    logic [xlen-1:0] estat;
    logic [xlen-1:0] badv;
    logic [xlen-1:0] save0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd  <= crmd_reset;
            era   <= '0;
            estat <= '0;
            badv  <= '0;
            save0 <= '0;
        end else if (ex_commit) begin
            // exception entry drops to plv0 with interrupts off.
            crmd[crmd_plv_lsb +: 2] <= 2'b00;
            crmd[crmd_ie_bit]       <= 1'b0;
            era                     <= ex_pc;
            estat[estat_ecode_msb:estat_ecode_lsb] <= ex_ecode[estat_ecode_w-1:0];
            if (ex_ecode == ec_ale) begin
                badv <= ex_vaddr;   // only address faults.
            end
        end else if (csr_we) begin
            case (csr_waddr)
                csr_era:   era   <= csr_wdata;
                csr_save0: save0 <= csr_wdata;
                default:   ;        // read-only here.
            endcase
        end
    end

    // flush follows the commit by one cycle.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            flush   <= 1'b0;
            ecode_q <= ec_none;
        end else begin
            flush <= ex_commit;
            if (ex_commit) begin
                ecode_q <= ex_ecode;
            end
        end
    end

    always_comb begin
        case (raddr)
            csr_crmd:  rdata = crmd;
            csr_era:   rdata = era;
            csr_estat: rdata = estat;
            csr_badv:  rdata = badv;
            csr_save0: rdata = save0;
            default:   rdata = '0;
        endcase
    end

endmodule

//--- hw/wb_top.sv
module wb_top import wb_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  mem_op_e               in_op,
    input  logic [xlen-1:0]       in_pc,
    input  logic [reg_addr_w-1:0] in_dest,
    input  logic [xlen-1:0]       in_alu_result,
    input  logic [xlen-1:0]       in_mem_rdata,
    input  logic [csr_addr_w-1:0] in_csr_addr,
    input  logic [xlen-1:0]       in_csr_wdata,

    input  logic [reg_addr_w-1:0] rf_raddr,
    output logic [xlen-1:0]       rf_rdata,
    input  logic [csr_addr_w-1:0] csr_raddr,
    output logic [xlen-1:0]       csr_rdata,

    output logic                  ex_valid,
    output ecode_e                ex_ecode,

    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    logic                  flush;
    logic                  w_allowin;
    logic                  m_valid;
    logic [xlen-1:0]       m_pc;
    logic [xlen-1:0]       m_result;
    logic                  m_rf_we;
    logic [reg_addr_w-1:0] m_dest;
    logic [xlen-1:0]       m_vaddr;
    logic                  m_ex;
    ecode_e                m_ecode;
    logic                  m_csr_we;
    logic [csr_addr_w-1:0] m_csr_addr;
    logic [xlen-1:0]       m_csr_wdata;

    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;
    logic                  ex_commit;
    ecode_e                wb_ecode;
    logic [xlen-1:0]       ex_pc;
    logic [xlen-1:0]       ex_vaddr;
    logic                  csr_we;
    logic [csr_addr_w-1:0] csr_waddr;
    logic [xlen-1:0]       csr_wdata;

    mem_stage u_mem (
        .clk, .rstn,
        .in_valid, .in_ready, .in_op, .in_pc, .in_dest,
        .in_alu_result, .in_mem_rdata, .in_csr_addr, .in_csr_wdata,
        .flush, .w_allowin,
        .m_valid, .m_pc, .m_result, .m_rf_we, .m_dest, .m_vaddr,
        .m_ex, .m_ecode, .m_csr_we, .m_csr_addr, .m_csr_wdata
    );

    wb_stage u_wb (
        .clk, .rstn, .flush,
        .m_valid, .w_allowin, .m_pc, .m_result, .m_rf_we, .m_dest,
        .m_vaddr, .m_ex, .m_ecode, .m_csr_we, .m_csr_addr, .m_csr_wdata,
        .rf_we, .rf_waddr, .rf_wdata,
        .ex_commit, .ex_ecode(wb_ecode), .ex_pc, .ex_vaddr,
        .csr_we, .csr_waddr, .csr_wdata,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    reg_file u_rf (
        .clk,
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .raddr(rf_raddr), .rdata(rf_rdata)
    );

    // flush doubles as the exception report.
    csr_file u_csr (
        .clk, .rstn,
        .ex_commit, .ex_ecode(wb_ecode), .ex_pc, .ex_vaddr,
        .csr_we, .csr_waddr, .csr_wdata,
        .raddr(csr_raddr), .rdata(csr_rdata),
        .flush, .ecode_q(ex_ecode)
    );

    assign ex_valid = flush;

endmodule

//--- testbench/wb_top_sva.sv
module wb_top_sva (
    input logic       clk,
    input logic       rstn,
    input logic       flush,
    input logic       in_ready,
    input logic       ex_commit,
    input logic [3:0] debug_wb_rf_we
);

    int fail_count = 0;   // failed assertion count.

    a_flush_pulse: assert property (@(posedge clk) disable iff (!rstn) flush |=> !flush)
        else begin
            $error("flush stayed high for a second cycle");
            fail_count++;
        end

    a_ready_in_flush: assert property (@(posedge clk) disable iff (!rstn) flush |-> !in_ready)
        else begin
            $error("in_ready high while flush is active");
            fail_count++;
        end

    a_no_write_on_ex: assert property (@(posedge clk) disable iff (!rstn)
        ex_commit |-> (debug_wb_rf_we == 4'b0000))
        else begin
            $error("register write reported together with an exception commit");
            fail_count++;
        end

endmodule

//--- testbench/tb_clock.sv
module tb_clock (
    output logic clk
);

    // 40 unit period.
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule

//--- testbench/tb_wb_top.sv
module tb_wb_top import wb_pkg::*; ();

    typedef struct packed {
        mem_op_e               op;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       alu;
        logic [xlen-1:0]       rdata;
        logic [csr_addr_w-1:0] csr_addr;
        logic [xlen-1:0]       csr_wdata;
        logic                  drop;     // killed by the preceding exception.
    } row_t;

    logic clk, rstn, in_valid, in_ready, ex_valid;
    mem_op_e in_op;
    ecode_e ex_ecode;
    logic [xlen-1:0] in_pc, in_alu_result, in_mem_rdata, in_csr_wdata;
    logic [xlen-1:0] rf_rdata, csr_rdata, debug_wb_pc, debug_wb_rf_wdata;
    logic [reg_addr_w-1:0] in_dest, rf_raddr, debug_wb_rf_wnum;
    logic [csr_addr_w-1:0] in_csr_addr, csr_raddr;
    logic [3:0] debug_wb_rf_we;

    row_t rows[$];
    string names[$];
    int max_wait = 50;
    int check_count = 0;
    int err_count = 0;
    bit timed_out = 1'b0;
    logic [xlen-1:0] model_rf [32];
    logic [xlen-1:0] m_crmd, m_era, m_estat, m_badv, m_save0;

    tb_clock u_clk (.clk);

    wb_top u_dut (
        .clk, .rstn, .in_valid, .in_ready, .in_op, .in_pc, .in_dest,
        .in_alu_result, .in_mem_rdata, .in_csr_addr, .in_csr_wdata,
        .rf_raddr, .rf_rdata, .csr_raddr, .csr_rdata, .ex_valid, .ex_ecode,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    bind wb_top wb_top_sva u_sva (
        .clk(clk), .rstn(rstn), .flush(flush), .in_ready(in_ready),
        .ex_commit(ex_commit), .debug_wb_rf_we(debug_wb_rf_we)
    );

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_row(input string name, input mem_op_e op, input logic [4:0] dest,
                           input logic [31:0] alu, input logic [31:0] rdata,
                           input logic [13:0] csr_addr, input logic [31:0] csr_wdata,
                           input logic drop);
        row_t r;
        r.op = op;
        r.pc = 32'h1c00_0000 + 32'(rows.size()) * 32'd4;   // unique per row.
        r.dest = dest;
        r.alu = alu;
        r.rdata = rdata;
        r.csr_addr = csr_addr;
        r.csr_wdata = csr_wdata;
        r.drop = drop;
        rows.push_back(r);
        names.push_back(name);
    endtask

    function automatic logic [31:0] expected_result(mem_op_e op, logic [31:0] alu,
                                                    logic [31:0] rdata);
        logic [7:0] b;
        b = rdata[8*alu[1:0] +: 8];
        if (op == op_ld_w) return rdata;
        if (op == op_ld_b) return {{24{b[7]}}, b};
        return alu;
    endfunction

    function automatic logic [7:0] expected_ecode(mem_op_e op, logic [31:0] alu);
        if (op == op_syscall) return 8'h0b;
        if ((op == op_ld_w || op == op_st_w) && alu[1:0] != 2'b00) return 8'h09;
        return 8'h00;
    endfunction

    function automatic logic [31:0] model_csr(logic [13:0] addr);
        if (addr == csr_crmd) return m_crmd;
        if (addr == csr_era) return m_era;
        if (addr == csr_estat) return m_estat;
        if (addr == csr_badv) return m_badv;
        if (addr == csr_save0) return m_save0;
        return 32'h0;
    endfunction

    task automatic read_rf(input logic [4:0] addr, output logic [31:0] value);
        rf_raddr = addr;
        @(negedge clk);
        value = rf_rdata;
    endtask

    task automatic read_csr(input logic [13:0] addr, output logic [31:0] value);
        csr_raddr = addr;
        @(negedge clk);
        value = csr_rdata;
    endtask

    task automatic send_row(input int i);
        int n;
        n = 0;
        in_op = rows[i].op;
        in_pc = rows[i].pc;
        in_dest = rows[i].dest;
        in_alu_result = rows[i].alu;
        in_mem_rdata = rows[i].rdata;
        in_csr_addr = rows[i].csr_addr;
        in_csr_wdata = rows[i].csr_wdata;
        in_valid = 1'b1;
        while (!in_ready && n < max_wait) begin
            @(negedge clk);
            n++;
        end
        if (!in_ready) begin
            $display("timeout: in_ready stayed low for row %s", names[i]);
            err_count++;
            timed_out = 1'b1;
        end else begin
            @(negedge clk);   // accepted on the rising edge.
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_for_outcome(input bit want_ex, input logic [31:0] pc, input string name);
        int n;
        n = 0;
        while (!(want_ex ? ex_valid : (debug_wb_pc === pc)) && n < max_wait) begin
            @(negedge clk);
            n++;
        end
        if (!(want_ex ? ex_valid : (debug_wb_pc === pc))) begin
            $display("timeout: row %s produced no writeback or exception", name);
            err_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_row(input int i);
        row_t r;
        logic [7:0] ec;
        logic we;
        logic [31:0] res;
        logic [31:0] v;
        int drop_idx;
        r = rows[i];
        ec = expected_ecode(r.op, r.alu);
        we = (r.op == op_alu || r.op == op_ld_w || r.op == op_ld_b) && ec == 8'h00;
        res = expected_result(r.op, r.alu, r.rdata);
        drop_idx = -1;
        send_row(i);
        if (ec != 8'h00 && i + 1 < rows.size() && rows[i + 1].drop) begin
            drop_idx = i + 1;
            send_row(drop_idx);   // back to back.
        end
        wait_for_outcome(ec != 8'h00, r.pc, names[i]);
        if (timed_out) return;
        if (ec != 8'h00) begin
            m_era = r.pc;
            m_estat[21:16] = ec[5:0];
            if (ec == 8'h09) m_badv = r.alu;
            check({names[i], " ecode"}, 32'(ec), 32'(ex_ecode));
            read_csr(csr_era, v);
            check({names[i], " era"}, m_era, v);
            read_csr(csr_estat, v);
            check({names[i], " estat"}, m_estat, v);
            read_csr(csr_badv, v);
            check({names[i], " badv"}, m_badv, v);
        end else begin
            check({names[i], " debug we"}, 32'(we ? 4'hf : 4'h0), 32'(debug_wb_rf_we));
            if (we) begin
                check({names[i], " debug wnum"}, 32'(r.dest), 32'(debug_wb_rf_wnum));
                check({names[i], " debug wdata"}, res, debug_wb_rf_wdata);
                if (r.dest != 5'd0) model_rf[r.dest] = res;
            end
            if (r.op == op_csrwr) begin
                if (r.csr_addr == csr_save0) m_save0 = r.csr_wdata;
                else if (r.csr_addr == csr_era) m_era = r.csr_wdata;
                read_csr(r.csr_addr, v);
                check({names[i], " csr"}, model_csr(r.csr_addr), v);
            end
        end
        read_rf(r.dest, v);
        check({names[i], " rf"}, model_rf[r.dest], v);
        if (drop_idx >= 0) begin
            read_rf(rows[drop_idx].dest, v);
            check({names[drop_idx], " rf"}, model_rf[rows[drop_idx].dest], v);
        end
    endtask

    initial begin
        logic [31:0] v;
        void'($urandom(72236));
        rstn = 1'b0;
        in_valid = 1'b0;
        in_op = op_alu;
        in_pc = '0;
        in_dest = '0;
        in_alu_result = '0;
        in_mem_rdata = '0;
        in_csr_addr = '0;
        in_csr_wdata = '0;
        rf_raddr = '0;
        csr_raddr = '0;
        for (int k = 0; k < 32; k++) model_rf[k] = 32'h0;
        m_crmd = 32'h8;
        m_era = 32'h0;
        m_estat = 32'h0;
        m_badv = 32'h0;
        m_save0 = 32'h0;

        add_row("alu_rand_r1", op_alu, 5'd1, $urandom, 32'h0, 14'h0, 32'h0, 1'b0);
        add_row("alu_r2", op_alu, 5'd2, 32'h1234_5678, 32'h0, 14'h0, 32'h0, 1'b0);
        add_row("alu_r0", op_alu, 5'd0, 32'hdead_beef, 32'h0, 14'h0, 32'h0, 1'b0);
        add_row("ld_w_ok", op_ld_w, 5'd3, 32'h0000_1000, 32'hcafe_f00d, 14'h0, 32'h0, 1'b0);
        add_row("ld_b_lane0", op_ld_b, 5'd4, 32'h0000_1000, 32'h0000_0080, 14'h0, 32'h0, 1'b0);
        add_row("ld_b_lane1", op_ld_b, 5'd5, 32'h0000_1001, 32'h0000_7f00, 14'h0, 32'h0, 1'b0);
        add_row("ld_b_lane2", op_ld_b, 5'd6, 32'h0000_1002, 32'h00a5_0000, 14'h0, 32'h0, 1'b0);
        add_row("ld_b_lane3", op_ld_b, 5'd7, 32'h0000_1003, 32'h4400_0000, 14'h0, 32'h0, 1'b0);
        add_row("alu_rand_r8", op_alu, 5'd8, $urandom, 32'h0, 14'h0, 32'h0, 1'b0);
        add_row("ld_w_misaligned", op_ld_w, 5'd3, 32'h0000_2002, 32'h1111_2222, 14'h0,
                32'h0, 1'b0);
        add_row("st_w_ok", op_st_w, 5'd1, 32'h0000_3000, 32'h0, 14'h0, 32'h0, 1'b0);
        add_row("syscall", op_syscall, 5'd0, 32'h0, 32'h0, 14'h0, 32'h0, 1'b0);
        add_row("alu_after_syscall", op_alu, 5'd2, 32'h5555_aaaa, 32'h0, 14'h0, 32'h0, 1'b1);
        add_row("csrwr_save0", op_csrwr, 5'd0, 32'h0, 32'h0, csr_save0, 32'h0bad_f00d, 1'b0);
        add_row("csrwr_crmd", op_csrwr, 5'd0, 32'h0, 32'h0, csr_crmd, 32'hffff_ffff, 1'b0);
        add_row("alu_recover", op_alu, 5'd10, $urandom, 32'h0, 14'h0, 32'h0, 1'b0);

        repeat (3) @(negedge clk);
        rstn = 1'b1;
        check("reset in_ready", 32'h1, 32'(in_ready));
        check("reset ex_valid", 32'h0, 32'(ex_valid));
        check("reset debug we", 32'h0, 32'(debug_wb_rf_we));
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            if (!rows[i].drop) run_row(i);
        end
        if (!timed_out) begin
            read_csr(csr_crmd, v);
            check("final crmd", m_crmd, v);
            read_csr(csr_save0, v);
            check("final save0", m_save0, v);
        end

        $display("checks run: %0d, errors: %0d, assertion failures: %0d",
                 check_count, err_count, u_dut.u_sva.fail_count);
        if (err_count == 0 && u_dut.u_sva.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- filelist.f
hw/wb_pkg.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/reg_file.sv
hw/csr_file.sv
hw/wb_top.sv
testbench/wb_top_sva.sv
testbench/tb_clock.sv
testbench/tb_wb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator and run the testbench; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_wb_top -f filelist.f -o sim \
    && ./obj_dir/sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation reported errors"; exit 1; }
exit 0
